// ==== logic/icacheGeomPkg.sv ====
// ==================================================
// Instruction cache geometry
// Line, word and fetch widths for the TMR line RAM,
// plus the XOR masks that keep the copies distinct
// ==================================================

package icacheGeomPkg;

        // ==================================================
        // widths
        // ==================================================

        // one cache line, also the width of a fetched instruction window
        typedef logic [127:0] lineT;

        // one fill word as it arrives over the bus
        typedef logic [31:0] wordT;

        // line index, address bits 12 to 4
        typedef logic [8:0] lineIdxT;

        // byte offset within a line, address bits 3 to 0
        typedef logic [3:0] byteOffT;

        typedef logic [31:0] pcT;

        // word position within a line, address bits 3 to 2
        typedef logic [1:0] wordSelT;

        localparam int numLines = 512;

        // ==================================================
        // copy masks
        // ==================================================

        // copy a is stored as is, b and c under complementary patterns
        localparam wordT maskB = 32'hAAAA_AAAA;
        localparam wordT maskC = 32'h5555_5555;

endpackage

// ==== logic/axiLitePkg.sv ====
// ==================================================
// AXI4-Lite fill port definitions
// Response codes, copy select decode of the fill
// address and the write slave FSM states
// ==================================================

package axiLitePkg;

        // write target, decoded from address bits 14 to 13
        typedef enum logic [1:0] {
                copyAll = 2'b00,
                copyA   = 2'b01,
                copyB   = 2'b10,
                copyC   = 2'b11
        } copySelT;

        localparam logic [1:0] respOkay = 2'b00;

        // idle accepts a write, respond waits for the B handshake
        typedef enum logic {
                fillIdle    = 1'b0,
                fillRespond = 1'b1
        } fillStateT;

endpackage

// ==== logic/fillAxiSlave.sv ====
// ==================================================
// AXI4-Lite fill slave
// Accepts one write at a time and turns it into a
// word write into the TMR line RAM, with copy select
// ==================================================

`timescale 1ns/1ps

module fillAxiSlave (
        input  logic                    wclk,
        input  logic                    arstN,
        input  logic                    awvalid,
        output logic                    awready,
        input  icacheGeomPkg::pcT       awaddr,
        input  logic                    wvalid,
        output logic                    wready,
        input  icacheGeomPkg::wordT     wdata,
        input  logic [3:0]              wstrb,
        output logic                    bvalid,
        input  logic                    bready,
        output logic [1:0]              bresp,
        output logic                    wordWe,
        output icacheGeomPkg::lineIdxT  wordLine,
        output icacheGeomPkg::wordSelT  wordSel,
        output icacheGeomPkg::wordT     wordData,
        output axiLitePkg::copySelT     copySel
);

        axiLitePkg::fillStateT state;
        logic accept;

        // address and data are taken together, only when both are offered
        assign accept = (state == axiLitePkg::fillIdle) && awvalid && wvalid;

        assign awready = accept;
        assign wready  = accept;

        // ==================================================
        // response FSM
        // ==================================================

        always_ff @(posedge wclk or negedge arstN) begin
                if (!arstN) begin
                        state <= axiLitePkg::fillIdle;
                end else begin
                        case (state)
                                axiLitePkg::fillIdle: begin
                                        if (accept) begin
                                                state <= axiLitePkg::fillRespond;
                                        end
                                end
                                axiLitePkg::fillRespond: begin
                                        if (bready) begin
                                                state <= axiLitePkg::fillIdle;
                                        end
                                end
                                default: state <= axiLitePkg::fillIdle;
                        endcase
                end
        end

        assign bvalid = (state == axiLitePkg::fillRespond);
        assign bresp  = axiLitePkg::respOkay;

        // ==================================================
        // word write decode
        // ==================================================

        // the RAM takes the word at the accepting edge. Byte strobes play no
        // part here since the fill always moves whole words
        assign wordWe   = accept;
        assign wordLine = awaddr[12:4];
        assign wordSel  = awaddr[3:2];
        assign wordData = wdata;
        assign copySel  = axiLitePkg::copySelT'(awaddr[14:13]);

endmodule

// ==== logic/tmrLineRam.sv ====
// ==================================================
// TMR line RAM, fetch stage 1
// Three masked copies of 512 lines, each read at the
// fetch line and the line after it in one cycle
// ==================================================

`timescale 1ns/1ps

module tmrLineRam (
        input  logic                    wclk,
        input  logic                    arstN,
        input  logic                    wordWe,
        input  icacheGeomPkg::lineIdxT  wordLine,
        input  icacheGeomPkg::wordSelT  wordSel,
        input  icacheGeomPkg::wordT     wordData,
        input  axiLitePkg::copySelT     copySel,
        input  logic                    fetchValid,
        input  icacheGeomPkg::pcT       pc,
        output icacheGeomPkg::lineT     evenA,
        output icacheGeomPkg::lineT     evenB,
        output icacheGeomPkg::lineT     evenC,
        output icacheGeomPkg::lineT     oddA,
        output icacheGeomPkg::lineT     oddB,
        output icacheGeomPkg::lineT     oddC,
        output icacheGeomPkg::byteOffT  offOut,
        output logic                    validOut
);

        icacheGeomPkg::lineIdxT loIdx;
        icacheGeomPkg::lineIdxT hiIdx;

        // the upper line wraps from 511 back to 0 through the 9 bit index
        assign loIdx = pc[12:4];
        assign hiIdx = icacheGeomPkg::lineIdxT'(loIdx + 1'b1);

        // ==================================================
        // storage, one array per copy
        // ==================================================

        for (genvar c = 0; c < 3; c++) begin : gCopy
                localparam icacheGeomPkg::wordT copyMask = (c == 0) ? '0 :
                        (c == 1) ? icacheGeomPkg::maskB : icacheGeomPkg::maskC;

                icacheGeomPkg::lineT mem [icacheGeomPkg::numLines];
                icacheGeomPkg::lineT rdLo;
                icacheGeomPkg::lineT rdHi;
                logic copyWe;

                // a copy is written by a normal fill or by injection aimed at it
                assign copyWe = wordWe && (copySel == axiLitePkg::copyAll ||
                        copySel == axiLitePkg::copySelT'(c + 1));

                // a same cycle write and read of one line returns the old line
                always_ff @(posedge wclk) begin
                        if (copyWe) begin
                                mem[wordLine][{wordSel, 5'b00000} +: 32] <= wordData ^ copyMask;
                        end
                        if (fetchValid) begin
                                rdLo <= mem[loIdx];
                                rdHi <= mem[hiIdx];
                        end
                end
        end

        assign evenA = gCopy[0].rdLo;
        assign evenB = gCopy[1].rdLo;
        assign evenC = gCopy[2].rdLo;
        assign oddA  = gCopy[0].rdHi;
        assign oddB  = gCopy[1].rdHi;
        assign oddC  = gCopy[2].rdHi;

        // offset and valid travel alongside the read data
        always_ff @(posedge wclk or negedge arstN) begin
                if (!arstN) begin
                        validOut <= 1'b0;
                end else begin
                        validOut <= fetchValid;
                end
        end

        always_ff @(posedge wclk) begin
                offOut <= pc[3:0];
        end

endmodule

// ==== logic/tmrVoter.sv ====
// ==================================================
// TMR voter, fetch stage 2
// Unmasks the three copies of both lines and takes
// a bitwise two of three vote, flagging any upset
// ==================================================

`timescale 1ns/1ps

module tmrVoter (
        input  icacheGeomPkg::lineT     evenA,
        input  icacheGeomPkg::lineT     evenB,
        input  icacheGeomPkg::lineT     evenC,
        input  icacheGeomPkg::lineT     oddA,
        input  icacheGeomPkg::lineT     oddB,
        input  icacheGeomPkg::lineT     oddC,
        input  icacheGeomPkg::byteOffT  offIn,
        input  logic                    validIn,
        output icacheGeomPkg::lineT     lineLo,
        output icacheGeomPkg::lineT     lineHi,
        output icacheGeomPkg::byteOffT  offOut,
        output logic                    validOut,
        output logic                    mismatch
);

        localparam icacheGeomPkg::lineT lineMaskB = {4{icacheGeomPkg::maskB}};
        localparam icacheGeomPkg::lineT lineMaskC = {4{icacheGeomPkg::maskC}};

        // returns the majority line and reports whether any copy disagreed
        function automatic icacheGeomPkg::lineT vote(input icacheGeomPkg::lineT a,
                        input icacheGeomPkg::lineT b, input icacheGeomPkg::lineT c,
                        output logic upset);
                icacheGeomPkg::lineT bU;
                icacheGeomPkg::lineT cU;
                icacheGeomPkg::lineT v;
                bU = b ^ lineMaskB;
                cU = c ^ lineMaskC;
                v = (a & bU) | (a & cU) | (bU & cU);
                upset = |((a ^ v) | (bU ^ v) | (cU ^ v));
                return v;
        endfunction

        logic upsetLo;
        logic upsetHi;

        always_comb begin
                lineLo = vote(evenA, evenB, evenC, upsetLo);
                lineHi = vote(oddA, oddB, oddC, upsetHi);
        end

        // a corrected upset in either line lets the core schedule a scrub
        assign mismatch = upsetLo | upsetHi;
        assign offOut   = offIn;
        assign validOut = validIn;

endmodule

// ==== logic/insnAligner.sv ====
// ==================================================
// Instruction aligner, fetch stage 3
// Picks 128 bits at any byte offset across two
// voted lines and registers the fetch result
// ==================================================

`timescale 1ns/1ps

module insnAligner (
        input  logic                    wclk,
        input  logic                    arstN,
        input  icacheGeomPkg::lineT     lineLo,
        input  icacheGeomPkg::lineT     lineHi,
        input  icacheGeomPkg::byteOffT  offIn,
        input  logic                    validIn,
        input  logic                    mismatchIn,
        output logic                    insnValid,
        output icacheGeomPkg::lineT     insn,
        output logic                    voteMismatch
);

        logic [255:0] window;

        // the high line sits above the low one, so a right shift by the
        // offset in bytes brings the wanted bytes down to bit 0
        assign window = {lineHi, lineLo} >> {offIn, 3'b000};

        always_ff @(posedge wclk or negedge arstN) begin
                if (!arstN) begin
                        insnValid    <= 1'b0;
                        voteMismatch <= 1'b0;
                end else begin
                        insnValid    <= validIn;
                        // only meaningful alongside a valid fetch
                        voteMismatch <= validIn & mismatchIn;
                end
        end

        always_ff @(posedge wclk) begin
                insn <= window[127:0];
        end

endmodule

// ==== logic/icacheTmr.sv ====
// ==================================================
// TMR instruction fetch memory
// AXI4-Lite fill slave feeding a three stage fetch
// pipeline: RAM read, vote, byte alignment
// ==================================================

`timescale 1ns/1ps

module icacheTmr (
        input  logic                    wclk,
        input  logic                    arstN,
        input  logic                    awvalid,
        output logic                    awready,
        input  icacheGeomPkg::pcT       awaddr,
        input  logic                    wvalid,
        output logic                    wready,
        input  icacheGeomPkg::wordT     wdata,
        input  logic [3:0]              wstrb,
        output logic                    bvalid,
        input  logic                    bready,
        output logic [1:0]              bresp,
        input  logic                    fetchValid,
        input  icacheGeomPkg::pcT       pc,
        output logic                    insnValid,
        output icacheGeomPkg::lineT     insn,
        output logic                    voteMismatch
);

        logic                   wordWe;
        icacheGeomPkg::lineIdxT wordLine;
        icacheGeomPkg::wordSelT wordSel;
        icacheGeomPkg::wordT    wordData;
        axiLitePkg::copySelT    copySel;

        icacheGeomPkg::lineT    evenA, evenB, evenC;
        icacheGeomPkg::lineT    oddA, oddB, oddC;
        icacheGeomPkg::byteOffT ramOff;
        logic                   ramValid;

        icacheGeomPkg::lineT    lineLo, lineHi;
        icacheGeomPkg::byteOffT voteOff;
        logic                   voteValid;
        logic                   mismatch;

        // ==================================================
        // fill side branch
        // ==================================================

        fillAxiSlave fillAxiSlave_inst (
                .wclk(wclk), .arstN(arstN),
                .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
                .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
                .bvalid(bvalid), .bready(bready), .bresp(bresp),
                .wordWe(wordWe), .wordLine(wordLine), .wordSel(wordSel),
                .wordData(wordData), .copySel(copySel)
        );

        // ==================================================
        // fetch pipeline
        // ==================================================

        tmrLineRam tmrLineRam_inst (
                .wclk(wclk), .arstN(arstN),
                .wordWe(wordWe), .wordLine(wordLine), .wordSel(wordSel),
                .wordData(wordData), .copySel(copySel),
                .fetchValid(fetchValid), .pc(pc),
                .evenA(evenA), .evenB(evenB), .evenC(evenC),
                .oddA(oddA), .oddB(oddB), .oddC(oddC),
                .offOut(ramOff), .validOut(ramValid)
        );

        tmrVoter tmrVoter_inst (
                .evenA(evenA), .evenB(evenB), .evenC(evenC),
                .oddA(oddA), .oddB(oddB), .oddC(oddC),
                .offIn(ramOff), .validIn(ramValid),
                .lineLo(lineLo), .lineHi(lineHi),
                .offOut(voteOff), .validOut(voteValid), .mismatch(mismatch)
        );

        insnAligner insnAligner_inst (
                .wclk(wclk), .arstN(arstN),
                .lineLo(lineLo), .lineHi(lineHi),
                .offIn(voteOff), .validIn(voteValid), .mismatchIn(mismatch),
                .insnValid(insnValid), .insn(insn), .voteMismatch(voteMismatch)
        );

endmodule

// ==== verification/icacheTmr_props.sv ====
// ==================================================
// TMR fetch memory assertions
// AXI write response rules and fetch latency
// ==================================================

`timescale 1ns/1ps

module icacheTmr_props (
        input logic wclk,
        input logic arstN,
        input logic awready,
        input logic bvalid,
        input logic bready,
        input logic fetchValid,
        input logic insnValid
);

        // a response stays up until the master takes it
        bvalidHeld: assert property (@(posedge wclk) disable iff (!arstN)
                bvalid && !bready |=> bvalid)
                else $error("bvalid dropped before bready was seen");

        noAcceptWhileBusy: assert property (@(posedge wclk) disable iff (!arstN)
                bvalid |-> !awready)
                else $error("write accepted while a response was pending");

        // the stage 1 and stage 3 registers give a fixed two cycle latency
        fetchLatency: assert property (@(posedge wclk) disable iff (!arstN)
                insnValid == $past(fetchValid, 2))
                else $error("insnValid does not follow fetchValid by two cycles");

endmodule

bind icacheTmr icacheTmr_props icacheTmr_props_inst (
        .wclk(wclk), .arstN(arstN), .awready(awready), .bvalid(bvalid),
        .bready(bready), .fetchValid(fetchValid), .insnValid(insnValid)
);

// ==== verification/icacheChecker.sv ====
// ==================================================
// Fetch result checker
// Shadows the fills seen on the bus and compares each
// fetch result and the write handshake against it
// ==================================================

`timescale 1ns/1ps

module icacheChecker (
        input  logic                    wclk,
        input  logic                    arstN,
        input  logic                    awvalid,
        input  logic                    awready,
        input  icacheGeomPkg::pcT       awaddr,
        input  logic                    wready,
        input  icacheGeomPkg::wordT     wdata,
        input  logic                    bvalid,
        input  logic                    bready,
        input  logic [1:0]              bresp,
        input  logic                    fetchValid,
        input  icacheGeomPkg::pcT       pc,
        input  logic                    expMismatch,
        input  logic                    insnValid,
        input  icacheGeomPkg::lineT     insn,
        input  logic                    voteMismatch,
        output int                      checks,
        output int                      errors
);

        icacheGeomPkg::lineT shadow [icacheGeomPkg::numLines];
        icacheGeomPkg::lineT expQ [$];
        icacheGeomPkg::pcT   pcQ [$];
        logic                misQ [$];
        logic [1:0]          validPipe;
        logic                bWait;

        // byte i of the result is byte off+i of the low line, or of the next line
        function automatic icacheGeomPkg::lineT expectedInsn(input icacheGeomPkg::pcT a);
                icacheGeomPkg::lineIdxT hiLine;
                icacheGeomPkg::lineT r;
                int b;
                hiLine = a[12:4] + 9'd1;
                for (int i = 0; i < 16; i++) begin
                        b = i + int'(a[3:0]);
                        if (b < 16) begin
                                r[8*i +: 8] = shadow[a[12:4]][8*b +: 8];
                        end else begin
                                r[8*i +: 8] = shadow[hiLine][8*(b-16) +: 8];
                        end
                end
                return r;
        endfunction

        always @(posedge wclk or negedge arstN) begin
                if (!arstN) begin
                        validPipe = 2'b00;
                        bWait = 1'b0;
                        checks = 0;
                        errors = 0;
                end else begin
                        if (insnValid != validPipe[1]) begin
                                errors++;
                                $display("insnValid at %0t does not follow a fetch by two cycles",
                                        $time);
                        end
                        if (insnValid && pcQ.size() > 0) begin
                                checks++;
                                if (insn != expQ[0] || voteMismatch != misQ[0]) begin
                                        errors++;
                                        $display("mismatch at %0t: pc %h insn %h/%b, want %h/%b",
                                                $time, pcQ[0], insn, voteMismatch, expQ[0],
                                                misQ[0]);
                                end else begin
                                        $display("test %0d: fetch at pc %h ok, vote %b",
                                                checks, pcQ[0], voteMismatch);
                                end
                                void'(pcQ.pop_front());
                                void'(expQ.pop_front());
                                void'(misQ.pop_front());
                        end
                        validPipe = {validPipe[0], fetchValid};
                        // the expected value is taken before a write at this same edge lands
                        if (fetchValid) begin
                                pcQ.push_back(pc);
                                expQ.push_back(expectedInsn(pc));
                                misQ.push_back(expMismatch);
                        end
                        if (bWait && !bvalid) begin
                                errors++;
                                $display("bvalid dropped at %0t before bready was seen", $time);
                        end
                        if (bvalid && awready) begin
                                errors++;
                                $display("write accepted at %0t while a response was pending",
                                        $time);
                        end
                        // address and data channels are always taken at the same edge
                        if (awready != wready) begin
                                errors++;
                                $display("awready and wready differ at %0t", $time);
                        end
                        if (bvalid && bresp != axiLitePkg::respOkay) begin
                                errors++;
                                $display("mismatch at %0t: bresp %b, expected OKAY",
                                        $time, bresp);
                        end
                        bWait = bvalid && !bready;
                        // injected single copy writes leave the shadow alone
                        if (awvalid && awready && awaddr[14:13] == 2'b00) begin
                                shadow[awaddr[12:4]][32*awaddr[3:2] +: 32] = wdata;
                        end
                end
        end

endmodule

// ==== verification/icacheTmrTb.sv ====
// ==================================================
// TMR fetch memory testbench
// Fills the RAM over AXI4-Lite, injects single copy
// upsets and runs fetches from a stimulus table
// ==================================================

`timescale 1ns/1ps

module icacheTmrTb;

        typedef enum logic [1:0] {opFill, opInject, opFetch, opStall} opT;

        // for a fill row data is a line count, and the lines get random words
        typedef struct packed {
                opT          op;
                logic [31:0] addr;
                logic [31:0] data;
                logic        expMis;
        } rowT;

        logic wclk = 1'b0;
        logic arstN, awvalid, awready, wvalid, wready, bvalid, bready;
        logic fetchValid, insnValid, voteMismatch, expMismatch;
        logic [3:0] wstrb;
        logic [1:0] bresp;
        icacheGeomPkg::pcT awaddr, pc;
        icacheGeomPkg::wordT wdata;
        icacheGeomPkg::lineT insn;
        int checks, errors;
        int busFailures = 0;
        int fetchRows = 0;
        rowT rows [$];

        always #5 wclk = ~wclk;

        icacheTmr icacheTmr_inst (.*);
        icacheChecker icacheChecker_inst (.*);

        task automatic addRow(input opT op, input logic [31:0] addr, input logic [31:0] data,
                        input logic expMis);
                rows.push_back('{op, addr, data, expMis});
                if (op == opFetch) begin
                        fetchRows++;
                end
        endtask

        task automatic offerWrite(input logic [31:0] addr, input logic [31:0] data);
                awaddr  = addr;
                wdata   = data;
                awvalid = 1'b1;
                wvalid  = 1'b1;
        endtask

        // waits for the slave to take the offered write, or for the B handshake
        task automatic awaitBus(input bit forResp);
                bit done;
                int t;
                t = 0;
                do begin
                        @(posedge wclk);
                        t++;
                        done = forResp ? (bvalid && bready) : awready;
                end while (!done && t < 50);
                if (!done) begin
                        busFailures++;
                        $display("bus timeout at %0t: no %s for address %h", $time,
                                forResp ? "write response" : "write acceptance", awaddr);
                end
                if (!forResp) begin
                        @(negedge wclk);
                        awvalid = 1'b0;
                        wvalid  = 1'b0;
                end
        endtask

        task automatic writeWord(input logic [31:0] addr, input logic [31:0] data);
                @(negedge wclk);
                offerWrite(addr, data);
                awaitBus(1'b0);
                awaitBus(1'b1);
        endtask

        // the second write is offered while the first response is held back
        task automatic blockedPair(input logic [31:0] addr, input logic [31:0] data);
                @(negedge wclk);
                bready = 1'b0;
                offerWrite(addr, data);
                awaitBus(1'b0);
                offerWrite(addr + 32'd4, {data[15:0], data[31:16]});
                repeat (4) @(negedge wclk);
                bready = 1'b1;
                awaitBus(1'b0);
                awaitBus(1'b1);
        endtask

        initial begin
                int waitCount;
                void'($urandom(32'he851));
                {arstN, awvalid, wvalid, fetchValid, expMismatch} = '0;
                bready = 1'b1;
                wstrb  = 4'hF;
                awaddr = '0;
                wdata  = '0;
                pc     = '0;
                addRow(opFill, 32'h0000_0000, 32'd10, 1'b0);
                addRow(opFill, 32'h0000_1FF0, 32'd1, 1'b0);
                for (int l = 0; l < 8; l++) begin
                        addRow(opFetch, 32'(16 * l), 32'd0, 1'b0);
                end
                for (int o = 1; o < 16; o++) begin
                        addRow(opFetch, 32'(32 + o), 32'd0, 1'b0);
                end
                addRow(opFetch, 32'h0000_1FF0, 32'd0, 1'b0);
                addRow(opFetch, 32'h0000_1FF9, 32'd0, 1'b0);
                // one upset each in copy a of line 4, copy b of line 6, copy c of line 7
                addRow(opInject, 32'h0000_2044, 32'h1234_5678, 1'b0);
                addRow(opInject, 32'h0000_4060, 32'h0F0F_00FF, 1'b0);
                addRow(opInject, 32'h0000_607C, 32'hFFFF_FFFF, 1'b0);
                addRow(opFetch, 32'h0000_0040, 32'd0, 1'b1);
                addRow(opFetch, 32'h0000_0036, 32'd0, 1'b1);
                addRow(opFetch, 32'h0000_0020, 32'd0, 1'b0);
                addRow(opFetch, 32'h0000_005A, 32'd0, 1'b1);
                addRow(opFetch, 32'h0000_0070, 32'd0, 1'b1);
                // normal writes over the upset lines clear them again
                addRow(opFill, 32'h0000_0040, 32'd1, 1'b0);
                addRow(opFill, 32'h0000_0060, 32'd2, 1'b0);
                addRow(opFetch, 32'h0000_0040, 32'd0, 1'b0);
                addRow(opFetch, 32'h0000_006C, 32'd0, 1'b0);
                addRow(opStall, 32'h0000_0084, 32'hC001_D00D, 1'b0);
                addRow(opFetch, 32'h0000_0080, 32'd0, 1'b0);
                addRow(opFetch, 32'h0000_007A, 32'd0, 1'b0);

                repeat (5) @(posedge wclk);
                @(negedge wclk);
                arstN = 1'b1;

                // fetch rows that follow each other go out on consecutive cycles
                foreach (rows[i]) begin
                        @(negedge wclk);
                        fetchValid = 1'b0;
                        case (rows[i].op)
                                opFetch: begin
                                        fetchValid  = 1'b1;
                                        pc          = rows[i].addr;
                                        expMismatch = rows[i].expMis;
                                end
                                opFill: begin
                                        for (int w = 0; w < 4 * int'(rows[i].data); w++) begin
                                                writeWord(rows[i].addr + 32'(4 * w), $urandom());
                                        end
                                        $display("row %0d: filled %0d lines at %h", i,
                                                rows[i].data, rows[i].addr);
                                end
                                opInject: begin
                                        writeWord(rows[i].addr, rows[i].data);
                                        $display("row %0d: injected %h at %h", i,
                                                rows[i].data, rows[i].addr);
                                end
                                opStall: begin
                                        blockedPair(rows[i].addr, rows[i].data);
                                        $display("row %0d: write pair behind a held response done", i);
                                end
                        endcase
                end
                @(negedge wclk);
                fetchValid = 1'b0;

                waitCount = 0;
                while (checks < fetchRows && waitCount < 20) begin
                        @(negedge wclk);
                        waitCount++;
                end
                if (checks < fetchRows) begin
                        busFailures++;
                        $display("only %0d of %0d fetch results arrived", checks, fetchRows);
                end
                $display("fetch tests %0d, value errors %0d, bus failures %0d", checks, errors,
                        busFailures);
                if (errors == 0 && busFailures == 0) begin
                        $display(">>> PASS");
                end else begin
                        $display(">>> FAIL");
                end
                $finish;
        end

endmodule

// ==== compile.f ====
logic/icacheGeomPkg.sv
logic/axiLitePkg.sv
logic/fillAxiSlave.sv
logic/tmrLineRam.sv
logic/tmrVoter.sv
logic/insnAligner.sv
logic/icacheTmr.sv
verification/icacheTmr_props.sv
verification/icacheChecker.sv
verification/icacheTmrTb.sv

// ==== Makefile ====
# Verilator build and run of the TMR instruction fetch memory testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module icacheTmrTb -f compile.f -Mdir obj_dir -o icacheTmrSim
	./obj_dir/icacheTmrSim | tee sim.log
	@if grep -q ">>> FAIL" sim.log; then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q ">>> PASS" sim.log; then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
